// ==== BranchPredictor.sv ====
/*
  Direct-mapped branch target buffer with two-bit counters.
  Looked up combinationally for every lane of the fetch group,
  trained by the branch outcome carried on the redirect port.
*/
`timescale 1ns/1ps

module BranchPredictor (
    input logic clk,
    input logic reset,
    input FetchTypes::PcPath [FetchTypes::FETCH_WIDTH-1:0] lanePc,
    output FetchTypes::BranchPred [FetchTypes::FETCH_WIDTH-1:0] lanePred,
    input FetchTypes::Redirect redirect
);
    import FetchTypes::*;

    logic [BTB_TAG_BITS-1:0] tagTable [BTB_ENTRIES];
    PcPath targetTable [BTB_ENTRIES];
    logic [1:0] counterTable [BTB_ENTRIES];

    logic [BTB_INDEX_BITS-1:0] lookupIndex [FETCH_WIDTH];
    logic [FETCH_WIDTH-1:0] lookupTaken;
    logic [BTB_INDEX_BITS-1:0] trainIndex;
    logic trainHit;

    // Entry select skips the bits below one instruction
    function automatic logic [BTB_INDEX_BITS-1:0] btbIndex(input PcPath pc);
        return pc[INSN_OFFSET_BITS +: BTB_INDEX_BITS];
    endfunction

    function automatic logic [BTB_TAG_BITS-1:0] btbTag(input PcPath pc);
        return pc[PC_WIDTH-1 -: BTB_TAG_BITS];
    endfunction

    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            lookupIndex[i] = btbIndex(lanePc[i]);
            // Taken needs a matching tag and a counter of 2 or more
            lookupTaken[i] = (tagTable[lookupIndex[i]] == btbTag(lanePc[i]))
                && (counterTable[lookupIndex[i]] >= 2'd2);
            lanePred[i].predTaken = lookupTaken[i];
            lanePred[i].predAddr = lookupTaken[i] ? targetTable[lookupIndex[i]]
                                                  : lanePc[i] + PcPath'(INSN_BYTES);
        end
        trainIndex = btbIndex(redirect.pc);
        trainHit = tagTable[trainIndex] == btbTag(redirect.pc);
    end

    // Taken outcome installs the branch and its target
    always_ff @(posedge clk) begin
        if (redirect.valid && redirect.taken) begin
            tagTable[trainIndex] <= btbTag(redirect.pc);
            targetTable[trainIndex] <= redirect.target;
        end
    end

    // Counters start weakly not-taken and saturate at 0 and 3
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                counterTable[i] <= 2'd1;
            end
        end else if (redirect.valid) begin
            if (redirect.taken) begin
                if (counterTable[trainIndex] != 2'd3) begin
                    counterTable[trainIndex] <= counterTable[trainIndex] + 2'd1;
                end
            end else if (trainHit && counterTable[trainIndex] != 2'd0) begin
                // Not-taken only weakens the branch already stored here
                counterTable[trainIndex] <= counterTable[trainIndex] - 2'd1;
            end
        end
    end

endmodule

// ==== FetchStage.sv ====
/*
  Fetch pipeline stage.
  Registers the group from the next-PC stage, reads it from the instruction cache,
  applies the lane predictions, flushes lanes after a predicted-taken lane,
  resolves the next fetch PC and hands the group on with a valid/ready handshake.
*/
`timescale 1ns/1ps

module FetchStage (
    input logic clk,
    input logic reset,
    input FetchTypes::Redirect redirect,
    input FetchTypes::PcGroup fetchPc,
    output logic advance,
    output FetchTypes::PcPath nextFetchPc,
    output logic lookupValid,
    output FetchTypes::PcPath lookupPc,
    input logic hit,
    input FetchTypes::CacheLine line,
    output FetchTypes::PcPath [FetchTypes::FETCH_WIDTH-1:0] lanePc,
    input FetchTypes::BranchPred [FetchTypes::FETCH_WIDTH-1:0] lanePred,
    output logic outValid,
    output FetchTypes::FetchGroup outGroup,
    input logic outReady
);
    import FetchTypes::*;

    // Pipeline register, lane valids plus the line base
    logic [FETCH_WIDTH-1:0] regValid;
    PcPath regBase;

    logic stall, regStall, beginStall, miss;
    // Predictions captured at the start of a stall
    BranchPred [FETCH_WIDTH-1:0] regPred;
    BranchPred [FETCH_WIDTH-1:0] pred;
    logic [FETCH_WIDTH-1:0] isFlushed;
    logic [FETCH_WIDTH-1:0] laneValid;
    logic takenFound;
    logic [LINE_OFFSET_BITS-INSN_OFFSET_BITS-1:0] laneOffset;

    always_comb begin
        lookupValid = |regValid;
        lookupPc = regBase;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            lanePc[i] = regBase + PcPath'(i * INSN_BYTES);
        end

        // Keep the prediction of the stalled group fixed
        pred = regStall ? regPred : lanePred;

        // First valid taken lane wins, later lanes are dropped
        takenFound = 1'b0;
        nextFetchPc = regBase + PcPath'(GROUP_BYTES);
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            isFlushed[i] = takenFound && regValid[i];
            laneValid[i] = regValid[i] && !takenFound;
            if (laneValid[i] && pred[i].predTaken) begin
                nextFetchPc = pred[i].predAddr;
            end
            takenFound = takenFound || (regValid[i] && pred[i].predTaken);
        end

        miss = lookupValid && !hit;
        outValid = (|laneValid) && hit;
        // Stall on a miss or when the consumer holds us
        stall = miss || (outValid && !outReady);
        beginStall = stall && !regStall;
        advance = fetchPc.valid && !stall && !redirect.valid;

        // Lanes below the entry point of the line are not fetched
        laneOffset = fetchPc.pc[LINE_OFFSET_BITS-1:INSN_OFFSET_BITS];

        for (int i = 0; i < FETCH_WIDTH; i++) begin
            outGroup.lane[i].valid = laneValid[i];
            outGroup.lane[i].pc = lanePc[i];
            outGroup.lane[i].insn = line.insn[i];
            outGroup.lane[i].pred = pred[i];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            regValid <= '0;
            regStall <= 1'b0;
        end else begin
            regStall <= stall;
            if (redirect.valid) begin
                regValid <= '0;
            end else if (!stall) begin
                for (int i = 0; i < FETCH_WIDTH; i++) begin
                    regValid[i] <= fetchPc.valid && (i >= laneOffset);
                end
            end else begin
                // Taken during a stall, drop the lanes behind it for good
                regValid <= regValid & ~isFlushed;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            regBase <= GroupBase(fetchPc.pc);
        end
        if (beginStall) begin
            regPred <= lanePred;
        end
    end

    // Held group must survive cache, predictor and handshake together
    aGroupHeld: assert property (
        @(posedge clk) disable iff (reset)
        outValid && !outReady && !redirect.valid |=> outValid && $stable(outGroup)
    ) else $error("Output group changed while stalled");

endmodule

// ==== FetchTypes.sv ====
/*
  Shared widths, geometry and packed structs of the two-lane fetch front end.
  Modules import this package inside their bodies and use scoped names in port lists.
*/
package FetchTypes;

    // Fetch group geometry, one group fills one cache line
    localparam int FETCH_WIDTH = 2;
    localparam int PC_WIDTH = 16;
    localparam int INSN_WIDTH = 32;
    localparam int INSN_BYTES = 4;
    localparam int GROUP_BYTES = FETCH_WIDTH * INSN_BYTES;

    // PC bits below one instruction and below one line
    localparam int INSN_OFFSET_BITS = $clog2(INSN_BYTES);
    localparam int LINE_OFFSET_BITS = $clog2(GROUP_BYTES);

    // Direct-mapped cache, indexed by line address
    localparam int CACHE_SETS = 8;
    localparam int CACHE_INDEX_BITS = $clog2(CACHE_SETS);
    localparam int CACHE_TAG_BITS = PC_WIDTH - LINE_OFFSET_BITS - CACHE_INDEX_BITS;

    // Target buffer, indexed by instruction address
    localparam int BTB_ENTRIES = 16;
    localparam int BTB_INDEX_BITS = $clog2(BTB_ENTRIES);
    localparam int BTB_TAG_BITS = PC_WIDTH - INSN_OFFSET_BITS - BTB_INDEX_BITS;

    typedef logic [PC_WIDTH-1:0] PcPath;
    typedef logic [INSN_WIDTH-1:0] InsnPath;

    typedef struct packed {
        logic predTaken;
        PcPath predAddr;
    } BranchPred;

    // One lane as it leaves the fetch stage
    typedef struct packed {
        logic valid;
        PcPath pc;
        InsnPath insn;
        BranchPred pred;
    } FetchLane;

    typedef struct packed {
        FetchLane [FETCH_WIDTH-1:0] lane;
    } FetchGroup;

    // Group start entering the fetch stage
    typedef struct packed {
        logic valid;
        PcPath pc;
    } PcGroup;

    // Restart target plus the branch outcome used for training
    typedef struct packed {
        logic valid;
        PcPath target;
        PcPath pc;
        logic taken;
    } Redirect;

    typedef struct packed {
        InsnPath [FETCH_WIDTH-1:0] insn;
    } CacheLine;

    // Start of the line that holds pc
    function automatic PcPath GroupBase(input PcPath pc);
        return pc & ~PcPath'(GROUP_BYTES - 1);
    endfunction

endpackage

// ==== FetchUnit.sv ====
/*
  Top level of the instruction-fetch front end.
  Ties the next-PC stage, branch predictor, instruction cache and fetch stage
  to the redirect, refill and output ports.
*/
`timescale 1ns/1ps

module FetchUnit (
    input logic clk,
    input logic reset,
    input FetchTypes::Redirect redirect,
    output logic refillValid,
    output FetchTypes::PcPath refillAddr,
    input logic refillReady,
    input logic respValid,
    input FetchTypes::CacheLine respLine,
    output logic outValid,
    output FetchTypes::FetchGroup outGroup,
    input logic outReady
);
    import FetchTypes::*;

    // Next-PC stage and fetch stage loop
    PcGroup fetchPc;
    logic advance;
    PcPath nextFetchPc;

    // Cache lookup
    logic lookupValid;
    PcPath lookupPc;
    logic hit;
    CacheLine line;

    // Predictor lookup per lane
    PcPath [FETCH_WIDTH-1:0] lanePc;
    BranchPred [FETCH_WIDTH-1:0] lanePred;

    NextPcStage nextPcStage (
        .clk(clk),
        .reset(reset),
        .redirect(redirect),
        .advance(advance),
        .nextFetchPc(nextFetchPc),
        .fetchPc(fetchPc)
    );

    BranchPredictor branchPredictor (
        .clk(clk),
        .reset(reset),
        .lanePc(lanePc),
        .lanePred(lanePred),
        .redirect(redirect)
    );

    InstructionCache instructionCache (
        .clk(clk),
        .reset(reset),
        .lookupValid(lookupValid),
        .lookupPc(lookupPc),
        .hit(hit),
        .line(line),
        .refillValid(refillValid),
        .refillAddr(refillAddr),
        .refillReady(refillReady),
        .respValid(respValid),
        .respLine(respLine)
    );

    FetchStage fetchStage (
        .clk(clk),
        .reset(reset),
        .redirect(redirect),
        .fetchPc(fetchPc),
        .advance(advance),
        .nextFetchPc(nextFetchPc),
        .lookupValid(lookupValid),
        .lookupPc(lookupPc),
        .hit(hit),
        .line(line),
        .lanePc(lanePc),
        .lanePred(lanePred),
        .outValid(outValid),
        .outGroup(outGroup),
        .outReady(outReady)
    );

endmodule

// ==== FetchUnitTb.sv ====
/*
  Testbench for the two-lane fetch unit.
  Serves refills from a random instruction memory with random ready and delay,
  applies random redirects and back-pressure, checks every transferred group
  against a path and content model, then trains one branch and checks its prediction.
*/
`timescale 1ns/1ps

module FetchUnitTb;
    import FetchTypes::*;

    localparam int MEM_WORDS = 16384;
    localparam int RANDOM_CYCLES = 3000;
    localparam int WAIT_LIMIT = 200;
    localparam int IDLE_LIMIT = 400;
    localparam int MIN_TRANSFERS = 100;

    // Wide enough for a whole output group
    typedef logic [$bits(FetchGroup)-1:0] CheckValue;

    logic clk;
    logic reset;
    Redirect redirect;
    logic refillValid;
    PcPath refillAddr;
    logic refillReady;
    logic respValid;
    CacheLine respLine;
    logic outValid;
    FetchGroup outGroup;
    logic outReady;

    integer seed = 32'he695;
    InsnPath mem [MEM_WORDS];

    // PC the next transferred group must start at
    PcPath expectedPc;
    int transfers;
    int idleCycles;
    logic holdValid;
    FetchGroup heldGroup;

    // Refill channel model
    logic reqWaiting;
    PcPath reqHeldAddr;
    int readyWait;
    logic respPending;
    int respDelay;
    PcPath respAddr;
    // Own copy of the direct-mapped tags
    PcPath modelTag [CACHE_SETS];
    logic modelValid [CACHE_SETS];

    // Trained branch under watch
    logic watchActive;
    logic watchSeen;
    PcPath watchAddr;
    PcPath watchTarget;

    FetchUnit UUT (
        .clk(clk),
        .reset(reset),
        .redirect(redirect),
        .refillValid(refillValid),
        .refillAddr(refillAddr),
        .refillReady(refillReady),
        .respValid(respValid),
        .respLine(respLine),
        .outValid(outValid),
        .outGroup(outGroup),
        .outReady(outReady)
    );

    always #50 clk = ~clk;

    task automatic stopWithFailure();
        $display("Testbench failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic checkEqual(input string name, input CheckValue expected,
                              input CheckValue actual);
        if (expected !== actual) begin
            $display("Fail %s expected %0h actual %0h", name, expected, actual);
            stopWithFailure();
        end
    endtask

    task automatic reportTimeout(input string what);
        $display("Timeout while %s", what);
        stopWithFailure();
    endtask

    function automatic InsnPath memWord(input PcPath pc);
        return mem[pc[PC_WIDTH-1:INSN_OFFSET_BITS]];
    endfunction

    // Mostly idle with targets kept in a small region so lines get reused
    function automatic Redirect randomRedirect();
        Redirect r;
        r.valid = ($random(seed) & 31) == 0;
        r.target = PcPath'($random(seed)) & PcPath'(16'h01fc);
        r.pc = PcPath'($random(seed)) & PcPath'(16'h01fc);
        r.taken = ($random(seed) & 3) == 0;
        return r;
    endfunction

    // One transferred group against content and path rules
    task automatic checkGroup();
        FetchLane lane;
        logic first;
        logic takenSeen;
        PcPath prevPc;
        first = 1'b1;
        takenSeen = 1'b0;
        prevPc = '0;
        transfers++;
        idleCycles = 0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            lane = outGroup.lane[i];
            if (lane.valid) begin
                checkEqual("lane after taken", CheckValue'(0), CheckValue'(takenSeen));
                if (first) begin
                    checkEqual("group start pc", CheckValue'(expectedPc), CheckValue'(lane.pc));
                end else begin
                    checkEqual("lane pc step", CheckValue'(prevPc + PcPath'(INSN_BYTES)),
                               CheckValue'(lane.pc));
                end
                checkEqual("lane insn", CheckValue'(memWord(lane.pc)), CheckValue'(lane.insn));
                // Not taken falls through to the next instruction
                if (!lane.pred.predTaken) begin
                    checkEqual("fall-through addr", CheckValue'(lane.pc + PcPath'(INSN_BYTES)),
                               CheckValue'(lane.pred.predAddr));
                end
                if (watchActive && lane.pc == watchAddr) begin
                    checkEqual("trained taken", CheckValue'(1), CheckValue'(lane.pred.predTaken));
                    checkEqual("trained target", CheckValue'(watchTarget),
                               CheckValue'(lane.pred.predAddr));
                    watchSeen = 1'b1;
                    watchActive = 1'b0;
                end
                prevPc = lane.pc;
                expectedPc = lane.pred.predAddr;
                takenSeen = lane.pred.predTaken;
                first = 1'b0;
            end
        end
        checkEqual("group with no valid lane", CheckValue'(0), CheckValue'(first));
    endtask

    // Values sampled at the falling edge meet the next rising edge
    task automatic observe();
        int idx;
        if (reqWaiting) begin
            checkEqual("refill valid held", CheckValue'(1), CheckValue'(refillValid));
            checkEqual("refill addr held", CheckValue'(reqHeldAddr), CheckValue'(refillAddr));
        end
        reqWaiting = 1'b0;
        if (refillValid) begin
            checkEqual("refill alignment", CheckValue'(0),
                       CheckValue'(refillAddr[LINE_OFFSET_BITS-1:0]));
            if (refillReady) begin
                idx = int'(refillAddr[LINE_OFFSET_BITS +: CACHE_INDEX_BITS]);
                checkEqual("refill of cached line", CheckValue'(0),
                           CheckValue'(modelValid[idx] && modelTag[idx] == refillAddr));
                respPending = 1'b1;
                respAddr = refillAddr;
                respDelay = $random(seed) & 3;
            end else begin
                reqWaiting = 1'b1;
                reqHeldAddr = refillAddr;
            end
        end

        // Group held under back-pressure unless a redirect empties the stage
        if (holdValid) begin
            checkEqual("held valid", CheckValue'(1), CheckValue'(outValid));
            checkEqual("held group", CheckValue'(heldGroup), CheckValue'(outGroup));
        end
        holdValid = outValid && !outReady && !redirect.valid;
        heldGroup = outGroup;

        if (outValid && outReady) begin
            checkGroup();
        end else begin
            idleCycles++;
            if (idleCycles > IDLE_LIMIT) begin
                reportTimeout("waiting for any group to be transferred");
            end
        end
        // A group leaving with the redirect is still on the old path
        if (redirect.valid) begin
            expectedPc = redirect.target;
        end
    endtask

    task automatic driveInputs(input Redirect nextRedirect);
        CacheLine fill;
        int idx;
        if (reqWaiting) begin
            readyWait++;
        end else begin
            readyWait = 0;
        end
        // Random ready that is forced after a short wait
        refillReady <= (readyWait >= 3) || (($random(seed) & 1) == 1);
        if (respPending && respDelay == 0) begin
            for (int i = 0; i < FETCH_WIDTH; i++) begin
                fill.insn[i] = memWord(respAddr + PcPath'(i * INSN_BYTES));
            end
            respValid <= 1'b1;
            respLine <= fill;
            idx = int'(respAddr[LINE_OFFSET_BITS +: CACHE_INDEX_BITS]);
            modelTag[idx] = respAddr;
            modelValid[idx] = 1'b1;
            respPending = 1'b0;
        end else begin
            if (respPending) begin
                respDelay--;
            end
            respValid <= 1'b0;
        end
        outReady <= ($random(seed) & 3) != 0;
        redirect <= nextRedirect;
    endtask

    task automatic stepCycle(input Redirect nextRedirect);
        @(negedge clk);
        observe();
        @(posedge clk);
        driveInputs(nextRedirect);
    endtask

    initial begin
        Redirect none;
        Redirect r;
        PcPath branchPc;
        PcPath branchTarget;
        int timeout;
        int seenCount;
        none = '0;
        clk = 1'b0;
        reset = 1'b1;
        redirect = '0;
        refillReady = 1'b0;
        respValid = 1'b0;
        respLine = '0;
        outReady = 1'b0;
        expectedPc = '0;
        transfers = 0;
        idleCycles = 0;
        holdValid = 1'b0;
        heldGroup = '0;
        reqWaiting = 1'b0;
        reqHeldAddr = '0;
        readyWait = 0;
        respPending = 1'b0;
        respDelay = 0;
        respAddr = '0;
        watchActive = 1'b0;
        watchSeen = 1'b0;
        watchAddr = '0;
        watchTarget = '0;
        for (int i = 0; i < CACHE_SETS; i++) begin
            modelValid[i] = 1'b0;
            modelTag[i] = '0;
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = $random(seed);
        end

        repeat (10) @(posedge clk);
        reset <= 1'b0;

        // Random traffic with redirects and some training
        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            stepCycle(randomRedirect());
        end

        // Two taken updates for one branch
        branchPc = PcPath'($random(seed)) & PcPath'(16'h01fc);
        branchTarget = PcPath'($random(seed)) & PcPath'(16'h0ffc);
        r = '0;
        r.valid = 1'b1;
        r.target = branchTarget;
        r.pc = branchPc;
        r.taken = 1'b1;
        stepCycle(r);
        repeat (3) stepCycle(none);
        stepCycle(r);
        repeat (3) stepCycle(none);

        // Restart at the branch while training a neighbour entry only
        watchAddr = branchPc;
        watchTarget = branchTarget;
        watchActive = 1'b1;
        r.target = branchPc;
        r.pc = branchPc + PcPath'(INSN_BYTES);
        r.taken = 1'b0;
        stepCycle(r);
        timeout = 0;
        while (!watchSeen) begin
            if (timeout >= WAIT_LIMIT) begin
                reportTimeout("waiting for the fetch of the trained branch");
            end
            stepCycle(none);
            timeout++;
        end

        // Next group is checked against the target by the path model
        seenCount = transfers;
        timeout = 0;
        while (transfers == seenCount) begin
            if (timeout >= WAIT_LIMIT) begin
                reportTimeout("waiting for the group at the branch target");
            end
            stepCycle(none);
            timeout++;
        end

        if (transfers < MIN_TRANSFERS) begin
            $display("Only %0d groups were transferred", transfers);
            stopWithFailure();
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

// ==== InstructionCache.sv ====
/*
  Direct-mapped instruction cache, one fetch group per line.
  The fetch stage looks up a group base and gets hit and line in the same cycle.
  A miss starts one refill over the valid/ready request channel and writes the response.
*/
`timescale 1ns/1ps

module InstructionCache (
    input logic clk,
    input logic reset,
    input logic lookupValid,
    input FetchTypes::PcPath lookupPc,
    output logic hit,
    output FetchTypes::CacheLine line,
    output logic refillValid,
    output FetchTypes::PcPath refillAddr,
    input logic refillReady,
    input logic respValid,
    input FetchTypes::CacheLine respLine
);
    import FetchTypes::*;

    typedef enum logic [1:0] {Idle, Request, Wait} RefillState;

    RefillState state;
    logic [CACHE_SETS-1:0] lineValid;
    logic [CACHE_TAG_BITS-1:0] tagArray [CACHE_SETS];
    CacheLine dataArray [CACHE_SETS];
    // Line being refilled
    PcPath reqAddr;

    logic [CACHE_INDEX_BITS-1:0] lookupIndex;
    logic [CACHE_INDEX_BITS-1:0] fillIndex;
    logic tagHit;
    logic startFill;

    always_comb begin
        lookupIndex = lookupPc[LINE_OFFSET_BITS +: CACHE_INDEX_BITS];
        fillIndex = reqAddr[LINE_OFFSET_BITS +: CACHE_INDEX_BITS];
        tagHit = lineValid[lookupIndex]
            && (tagArray[lookupIndex] == lookupPc[PC_WIDTH-1 -: CACHE_TAG_BITS]);
        // Lookups miss while a refill is out, so no line changes under a held group
        hit = tagHit && (state == Idle);
        line = dataArray[lookupIndex];
        startFill = (state == Idle) && lookupValid && !tagHit;
        refillValid = state == Request;
        refillAddr = reqAddr;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= Idle;
            lineValid <= '0;
        end else begin
            case (state)
                Idle: if (startFill) state <= Request;
                Request: if (refillReady) state <= Wait;
                Wait: begin
                    // Response has no ready, take it when it comes
                    if (respValid) begin
                        state <= Idle;
                        lineValid[fillIndex] <= 1'b1;
                    end
                end
                default: state <= Idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (startFill) begin
            reqAddr <= GroupBase(lookupPc);
        end
        if (state == Wait && respValid) begin
            tagArray[fillIndex] <= reqAddr[PC_WIDTH-1 -: CACHE_TAG_BITS];
            dataArray[fillIndex] <= respLine;
        end
    end

    aRefillHeld: assert property (
        @(posedge clk) disable iff (reset)
        refillValid && !refillReady |=> refillValid && $stable(refillAddr)
    ) else $error("Refill request dropped or changed before acceptance");

endmodule

// ==== NextPcStage.sv ====
/*
  Next-PC stage of the fetch front end.
  Holds the PC of the group being fetched and offers the PC of the next group,
  either a redirect target still waiting to enter or the fetch stage's resolved next PC.
*/
`timescale 1ns/1ps

module NextPcStage (
    input logic clk,
    input logic reset,
    input FetchTypes::Redirect redirect,
    input logic advance,
    input FetchTypes::PcPath nextFetchPc,
    output FetchTypes::PcGroup fetchPc
);
    import FetchTypes::*;

    // PC of the group in, or about to enter, the fetch stage
    PcPath pcReg;
    // pcReg has not been taken by the fetch stage yet
    logic pendReg;
    // Fetch starts the cycle after reset
    logic runReg;

    always_ff @(posedge clk) begin
        if (reset) begin
            pcReg <= '0;
            pendReg <= 1'b1;
            runReg <= 1'b0;
        end else begin
            runReg <= 1'b1;
            if (redirect.valid) begin
                // Restart, the fetch stage is emptied in the same cycle
                pcReg <= redirect.target;
                pendReg <= 1'b1;
            end else if (advance) begin
                pcReg <= fetchPc.pc;
                pendReg <= 1'b0;
            end
        end
    end

    always_comb begin
        fetchPc.valid = runReg;
        // Pending target first, else follow the group now in the fetch stage
        fetchPc.pc = pendReg ? pcReg : nextFetchPc;
    end

    // Both sources of a new PC come from outside this stage
    aPcAligned: assert property (
        @(posedge clk) disable iff (reset)
        (redirect.valid || advance) |=> (pcReg[INSN_OFFSET_BITS-1:0] == '0)
    ) else $error("Fetch PC not instruction aligned");

endmodule

// ==== build.f ====
FetchTypes.sv
NextPcStage.sv
BranchPredictor.sv
InstructionCache.sv
FetchStage.sv
FetchUnit.sv
FetchUnitTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the fetch unit testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
    --top-module FetchUnitTb -f build.f -o FetchUnitSim &&
./obj_dir/FetchUnitSim | tee /dev/stderr | grep -q "Testbench passed" &&
echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
